// ==== upscale_pkg.sv ====
// Up-scaler shared definitions
package upscale_pkg;

	// Pixel width, 8 bits each for r, g and b
	localparam int PIX_W = 24;

	// Stream word width on both AXI-Stream ports
	localparam int AXIS_W = 32;

	// One RGB pixel, red in the top byte
	typedef struct packed {
		logic [PIX_W/3-1:0] r;
		logic [PIX_W/3-1:0] g;
		logic [PIX_W/3-1:0] b;
	} rgb_pix_t;

	// Pixel view of a stream word
	// Upper byte is padding, low three bytes carry the pixel
	typedef struct packed {
		logic [AXIS_W-PIX_W-1:0] pad;
		rgb_pix_t                pix;
	} axis_pix_view_t;

	// Stream word, seen raw or as pad plus pixel
	typedef union packed {
		logic [AXIS_W-1:0] raw;
		axis_pix_view_t    px;
	} axis_word_u;

	// Output beat with its sideband flags
	typedef struct packed {
		axis_word_u data;
		logic       last;
		logic       user;
	} axis_beat_t;

	// Controller states, also used as the row phase
	typedef enum logic [2:0] {
		IDLE,
		START,
		FETCH,
		REPLAY,
		FINISH
	} ctrl_state_t;

endpackage

// ==== stream_in.sv ====
// AXI-Stream pixel intake
`timescale 1ns/1ps

module stream_in (
	input  logic                   clk,
	input  logic                   rst_n,
	// Pixel request from the controller
	input  logic                   upsp_ac_rd,
	// Frame start and frame end pulses
	input  logic                   upstr,
	input  logic                   upendr,
	// AXI-Stream slave
	input  logic                   s_axis_tvalid,
	input  upscale_pkg::axis_word_u s_axis_tdata,
	input  logic                   s_axis_tlast,
	output logic                   s_axis_tready,
	// Returned pixel, one cycle after the beat is taken
	output logic                   ac_upsp_rvalid,
	output upscale_pkg::rgb_pix_t  ac_upsp_rdata
);

	logic frame_done;
	logic accept;

	// Ready only while a pixel is wanted and the frame is still open
	assign s_axis_tready = upsp_ac_rd & ~frame_done;
	assign accept        = s_axis_tvalid & s_axis_tready;

	// Frame-done flag
	// Set by the tlast beat or by the end pulse, cleared by the next start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_done <= 1'b0;
		end else if (accept & s_axis_tlast) begin
			frame_done <= 1'b1;
		end else if (upendr) begin
			frame_done <= 1'b1;
		end else if (upstr) begin
			frame_done <= 1'b0;
		end
	end

	// One-cycle valid for each accepted beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac_upsp_rvalid <= 1'b0;
		end else begin
			ac_upsp_rvalid <= accept;
		end
	end

	// Keep only the pixel bytes, the pad byte is dropped here
	always_ff @(posedge clk) begin
		if (accept) begin
			ac_upsp_rdata <= s_axis_tdata.px.pix;
		end
	end

endmodule

// ==== upsp_ctrl.sv ====
// Up-sampler control FSM
`timescale 1ns/1ps

module upsp_ctrl #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     out_free,
	input  logic                     ac_upsp_rvalid,
	input  logic                     buf_rd_valid,
	input  logic                     last_col,
	input  logic                     last_row,
	input  logic                     out_done,
	output logic                     upsp_ac_rd,
	output logic                     upstr,
	output logic                     upendr,
	output logic                     buf_rd,
	output logic                     cnt_step,
	output logic                     cnt_clear,
	output logic                     load,
	output logic                     first,
	output logic                     final_pix,
	output upscale_pkg::ctrl_state_t phase,
	output logic                     busy
);

	// Loads per frame, every pixel goes out on a fetch row and a replay row
	localparam int N_LOADS = 2 * IMG_WIDTH * IMG_HEIGHT;
	localparam int LC_W    = $clog2(N_LOADS);

	upscale_pkg::ctrl_state_t state;
	upscale_pkg::ctrl_state_t state_nxt;
	logic                     in_fetch;
	logic                     in_replay;
	logic                     pix_ret;
	logic [LC_W-1:0]          load_cnt;

	assign in_fetch  = (state == upscale_pkg::FETCH);
	assign in_replay = (state == upscale_pkg::REPLAY);

	// Pixel coming back this cycle, so the request is still pending
	assign pix_ret = (in_fetch & ac_upsp_rvalid) | (in_replay & buf_rd_valid);

	// Requests wait for a free output stage and no pending return
	// Intake request stays up until a beat arrives
	assign upsp_ac_rd = in_fetch & out_free & ~ac_upsp_rvalid;
	assign buf_rd     = in_replay & out_free & ~buf_rd_valid;

	// Each returned pixel goes straight to the output stage
	assign load      = pix_ret;
	assign cnt_step  = pix_ret;
	assign first     = (load_cnt == '0);
	assign final_pix = (load_cnt == LC_W'(N_LOADS - 1));

	assign upstr     = (state == upscale_pkg::START);
	assign cnt_clear = (state == upscale_pkg::START);
	assign upendr    = (state == upscale_pkg::FINISH) & out_done;
	assign busy      = (state != upscale_pkg::IDLE);
	assign phase     = state;

	always_comb begin
		state_nxt = state;
		case (state)
			upscale_pkg::IDLE:   if (start) state_nxt = upscale_pkg::START;
			upscale_pkg::START:  state_nxt = upscale_pkg::FETCH;
			// Row ends on the load of the last column
			upscale_pkg::FETCH:  if (load & last_col) state_nxt = upscale_pkg::REPLAY;
			upscale_pkg::REPLAY: begin
				if (load & last_col) begin
					state_nxt = last_row ? upscale_pkg::FINISH : upscale_pkg::FETCH;
				end
			end
			// Wait for the last beat to leave
			upscale_pkg::FINISH: if (out_done) state_nxt = upscale_pkg::IDLE;
			default:             state_nxt = upscale_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= upscale_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Frame load count, marks first and final pixel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_cnt <= '0;
		end else if (upstr) begin
			load_cnt <= '0;
		end else if (load) begin
			load_cnt <= load_cnt + 1'b1;
		end
	end

endmodule

// ==== upsp_counter.sv ====
// Column and row position counter
`timescale 1ns/1ps

module upsp_counter #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 3,
	localparam int COL_W     = $clog2(IMG_WIDTH),
	localparam int ROW_W     = $clog2(IMG_HEIGHT)
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cnt_clear,
	input  logic                     cnt_step,
	// Current row phase from the controller
	input  upscale_pkg::ctrl_state_t phase,
	output logic [COL_W-1:0]         col,
	output logic [ROW_W-1:0]         row,
	output logic                     last_col,
	output logic                     last_row
);

	assign last_col = (col == COL_W'(IMG_WIDTH - 1));
	assign last_row = (row == ROW_W'(IMG_HEIGHT - 1));

	// Column counter wraps every row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
		end else if (cnt_clear) begin
			col <= '0;
		end else if (cnt_step) begin
			if (last_col) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Row moves on only after the replay pass
	// Fetch row wrap keeps the same input row for replay
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row <= '0;
		end else if (cnt_clear) begin
			row <= '0;
		end else if (cnt_step & last_col & (phase == upscale_pkg::REPLAY)) begin
			if (last_row) begin
				row <= '0;
			end else begin
				row <= row + 1'b1;
			end
		end
	end

endmodule

// ==== upsp_line_buf.sv ====
// Single-port line buffer
`timescale 1ns/1ps

module upsp_line_buf #(
	parameter int IMG_WIDTH = 4,
	localparam int ADDR_W   = $clog2(IMG_WIDTH)
) (
	input  logic                  clk,
	input  logic                  rst_n,
	// Write comes from fetch rows
	input  logic                  wr,
	// Read comes from replay rows
	input  logic                  rd,
	input  logic [ADDR_W-1:0]     addr,
	input  upscale_pkg::rgb_pix_t wdata,
	output logic                  rd_valid,
	output upscale_pkg::rgb_pix_t rdata
);

	// One input row of pixels
	upscale_pkg::rgb_pix_t mem [IMG_WIDTH];

	// Write port
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
	end

	// Registered read data
	always_ff @(posedge clk) begin
		if (rd) begin
			rdata <= mem[addr];
		end
	end

	// Read valid, one cycle after the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd;
		end
	end

endmodule

// ==== upsp_out.sv ====
// AXI-Stream output stage
`timescale 1ns/1ps

module upsp_out (
	input  logic                    clk,
	input  logic                    rst_n,
	// Pixel load from the controller
	input  logic                    load,
	input  upscale_pkg::rgb_pix_t   pix,
	input  logic                    first,
	input  logic                    final_pix,
	// AXI-Stream master
	input  logic                    m_axis_tready,
	output logic                    m_axis_tvalid,
	output upscale_pkg::axis_beat_t m_axis_beat,
	// Status back to the controller
	output logic                    out_free,
	output logic                    out_done
);

	logic                  full;
	// Low for the first beat, high for the duplicate
	logic                  half;
	logic                  first_q;
	logic                  final_q;
	upscale_pkg::rgb_pix_t pix_q;
	logic                  beat_go;

	assign m_axis_tvalid = full;
	assign beat_go       = full & m_axis_tready;

	// Free when empty or when the second beat leaves now
	assign out_free = ~full | (half & m_axis_tready);
	assign out_done = beat_go & half & final_q;

	// Both beats carry the same pixel with a zero pad byte
	always_comb begin
		m_axis_beat              = '0;
		m_axis_beat.data.px.pad  = '0;
		m_axis_beat.data.px.pix  = pix_q;
		m_axis_beat.user         = first_q & ~half;
		m_axis_beat.last         = final_q & half;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full    <= 1'b0;
			half    <= 1'b0;
			first_q <= 1'b0;
			final_q <= 1'b0;
		end else if (load) begin
			full    <= 1'b1;
			half    <= 1'b0;
			first_q <= first;
			final_q <= final_pix;
		end else if (beat_go) begin
			// Second beat sent, stage goes empty
			full <= ~half;
			half <= ~half;
		end
	end

	// Held pixel
	always_ff @(posedge clk) begin
		if (load) begin
			pix_q <= pix;
		end
	end

endmodule

// ==== upscale_top.sv ====
// 2x2 nearest-neighbour up-scaler
`timescale 1ns/1ps

module upscale_top #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 3
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start,
	output logic                            busy,
	// Input stream
	input  logic                            s_axis_tvalid,
	output logic                            s_axis_tready,
	input  logic [upscale_pkg::AXIS_W-1:0]  s_axis_tdata,
	input  logic                            s_axis_tlast,
	// Output stream
	output logic                            m_axis_tvalid,
	input  logic                            m_axis_tready,
	output upscale_pkg::axis_beat_t         m_axis_beat
);

	localparam int COL_W = $clog2(IMG_WIDTH);

	logic                     upsp_ac_rd;
	logic                     ac_upsp_rvalid;
	upscale_pkg::rgb_pix_t    ac_upsp_rdata;
	logic                     upstr;
	logic                     upendr;
	logic                     buf_rd;
	logic                     buf_wr;
	logic                     buf_rd_valid;
	upscale_pkg::rgb_pix_t    buf_rdata;
	logic                     cnt_step;
	logic                     cnt_clear;
	logic [COL_W-1:0]         col;
	logic                     last_col;
	logic                     last_row;
	logic                     load;
	logic                     first;
	logic                     final_pix;
	logic                     out_free;
	logic                     out_done;
	upscale_pkg::ctrl_state_t phase;
	upscale_pkg::rgb_pix_t    load_pix;

	// Fetch rows fill the line buffer as pixels arrive
	assign buf_wr = ac_upsp_rvalid & (phase == upscale_pkg::FETCH);

	// Intake pixel on fetch rows, buffered pixel on replay rows
	assign load_pix = (phase == upscale_pkg::FETCH) ? ac_upsp_rdata : buf_rdata;

	stream_in i_stream_in (
		.clk(clk), .rst_n(rst_n), .upsp_ac_rd(upsp_ac_rd), .upstr(upstr), .upendr(upendr),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tdata(s_axis_tdata),
		.s_axis_tlast(s_axis_tlast), .s_axis_tready(s_axis_tready),
		.ac_upsp_rvalid(ac_upsp_rvalid), .ac_upsp_rdata(ac_upsp_rdata)
	);

	upsp_ctrl #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .out_free(out_free),
		.ac_upsp_rvalid(ac_upsp_rvalid), .buf_rd_valid(buf_rd_valid),
		.last_col(last_col), .last_row(last_row), .out_done(out_done),
		.upsp_ac_rd(upsp_ac_rd), .upstr(upstr), .upendr(upendr), .buf_rd(buf_rd),
		.cnt_step(cnt_step), .cnt_clear(cnt_clear), .load(load), .first(first),
		.final_pix(final_pix), .phase(phase), .busy(busy)
	);

	// Row count stays inside the counter
	upsp_counter #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_counter (
		.clk(clk), .rst_n(rst_n), .cnt_clear(cnt_clear), .cnt_step(cnt_step),
		.phase(phase), .col(col), .row(), .last_col(last_col), .last_row(last_row)
	);

	upsp_line_buf #(.IMG_WIDTH(IMG_WIDTH)) i_line_buf (
		.clk(clk), .rst_n(rst_n), .wr(buf_wr), .rd(buf_rd), .addr(col),
		.wdata(ac_upsp_rdata), .rd_valid(buf_rd_valid), .rdata(buf_rdata)
	);

	upsp_out i_out (
		.clk(clk), .rst_n(rst_n), .load(load), .pix(load_pix), .first(first),
		.final_pix(final_pix), .m_axis_tready(m_axis_tready), .m_axis_tvalid(m_axis_tvalid),
		.m_axis_beat(m_axis_beat), .out_free(out_free), .out_done(out_done)
	);

endmodule

// ==== tb_upscale.sv ====
// Up-scaler testbench
`timescale 1ns/1ps

module tb_upscale;

	localparam int N_IN     = 12;
	localparam int N_OUT    = 48;
	localparam int N_FRAMES = 3;

	logic                             clk;
	logic                             rst_n;
	logic                             start;
	logic                             busy;
	logic                             s_axis_tvalid;
	logic                             s_axis_tready;
	logic [upscale_pkg::AXIS_W-1:0]   s_axis_tdata;
	logic                             s_axis_tlast;
	logic                             m_axis_tvalid;
	logic                             m_axis_tready;
	upscale_pkg::axis_beat_t          m_axis_beat;

	// Frame record from the trace
	logic [upscale_pkg::AXIS_W-1:0]   in_words [N_IN];
	logic [upscale_pkg::AXIS_W-1:0]   exp_words [N_OUT];
	// Output beats of the current frame
	upscale_pkg::axis_beat_t          beats [$];
	logic [31:0]                      lfsr;

	upscale_top #(.IMG_WIDTH(4), .IMG_HEIGHT(3)) i_dut (
		.clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
		.s_axis_tdata(s_axis_tdata), .s_axis_tlast(s_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
		.m_axis_beat(m_axis_beat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per random bit
	function automatic logic rand_bit();
		lfsr = lfsr_step(lfsr);
		return lfsr[0];
	endfunction

	// Nearest neighbour source pixel
	// Output row k/8 maps to input row k/16
	function automatic logic [31:0] upscaled_pixel(input int k);
		logic [31:0] src;
		src = in_words[(k / 16) * 4 + (k % 8) / 2];
		return {8'h00, src[23:0]};
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			stop_run($sformatf("** Error at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic run_frame(input int bp, input int gap);
		int                      in_idx;
		int                      cyc;
		logic                    stalled;
		logic                    pending;
		upscale_pkg::axis_beat_t held;
		in_idx  = 0;
		cyc     = 0;
		stalled = 1'b0;
		pending = 1'b0;
		held    = '0;
		beats.delete();
		// One-cycle start pulse
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		#1;
		check_value(32'(busy), 32'd1, "busy after start");
		while (beats.size() < N_OUT) begin
			@(negedge clk);
			if (in_idx < N_IN) begin
				// Optional valid gaps between beats
				// A beat that waits for ready stays on the bus
				if (!pending && gap != 0 && rand_bit()) begin
					s_axis_tvalid = 1'b0;
				end else begin
					s_axis_tvalid = 1'b1;
					s_axis_tdata  = in_words[in_idx];
					s_axis_tlast  = (in_idx == N_IN - 1);
				end
			end else begin
				// Extra beat after tlast must be refused
				s_axis_tvalid = 1'b1;
				s_axis_tdata  = 32'hdead_beef;
				s_axis_tlast  = 1'b0;
			end
			m_axis_tready = (bp != 0) ? rand_bit() : 1'b1;
			#1;
			check_value(32'(busy), 32'd1, "busy during frame");
			if (in_idx >= N_IN) begin
				check_value(32'(s_axis_tready), 32'd0, "tready after tlast");
			end
			// Stalled beat must hold still
			if (stalled) begin
				check_value(32'(m_axis_tvalid), 32'd1, "tvalid under stall");
				check_value(m_axis_beat.data.raw, held.data.raw, "data under stall");
				check_value(32'({m_axis_beat.last, m_axis_beat.user}),
					32'({held.last, held.user}), "flags under stall");
			end
			pending = s_axis_tvalid & ~s_axis_tready;
			if (s_axis_tvalid && s_axis_tready) begin
				in_idx++;
			end
			if (m_axis_tvalid && m_axis_tready) begin
				beats.push_back(m_axis_beat);
			end
			stalled = m_axis_tvalid & ~m_axis_tready;
			held    = m_axis_beat;
			cyc++;
			if (cyc > 2000) begin
				stop_run($sformatf("Timeout: frame output incomplete at %0t ns", $time));
			end
		end
		// Busy falls with no further beats and input still refused
		cyc = 0;
		while (busy) begin
			@(negedge clk);
			#1;
			check_value(32'(s_axis_tready), 32'd0, "tready before next start");
			check_value(32'(m_axis_tvalid), 32'd0, "tvalid after last beat");
			cyc++;
			if (cyc > 50) begin
				stop_run($sformatf("Timeout: busy still high at %0t ns", $time));
			end
		end
		@(negedge clk);
		s_axis_tvalid = 1'b0;
		for (int k = 0; k < N_OUT; k++) begin
			check_value(beats[k].data.raw, upscaled_pixel(k), $sformatf("beat %0d vs input", k));
			check_value(beats[k].data.raw, exp_words[k], $sformatf("beat %0d vs trace", k));
			check_value(32'(beats[k].user), 32'(k == 0), $sformatf("beat %0d tuser", k));
			check_value(32'(beats[k].last), 32'(k == N_OUT - 1), $sformatf("beat %0d tlast", k));
		end
	endtask

	initial begin
		int               fd;
		int               n;
		int               bp;
		int               gap;
		int               frames;
		logic [8*256-1:0] hdr_line;
		lfsr          = 32'hbc22_5dde;
		frames        = 0;
		rst_n         = 1'b0;
		start         = 1'b0;
		s_axis_tvalid = 1'b0;
		s_axis_tdata  = '0;
		s_axis_tlast  = 1'b0;
		m_axis_tready = 1'b0;
		fd = $fopen("upscale_trace.txt", "r");
		if (fd == 0) begin
			stop_run("Could not open upscale_trace.txt");
		end
		// Two column description lines
		repeat (2) n = $fgets(hdr_line, fd);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		n = $fscanf(fd, "%d %d", bp, gap);
		while (n == 2) begin
			for (int i = 0; i < N_IN; i++) begin
				if ($fscanf(fd, "%h", in_words[i]) != 1) begin
					stop_run("Trace ends inside the input words of a frame");
				end
			end
			for (int i = 0; i < N_OUT; i++) begin
				if ($fscanf(fd, "%h", exp_words[i]) != 1) begin
					stop_run("Trace ends inside the expected words of a frame");
				end
			end
			run_frame(bp, gap);
			frames++;
			n = $fscanf(fd, "%d %d", bp, gap);
		end
		$fclose(fd);
		if (frames != N_FRAMES) begin
			stop_run($sformatf("Trace held %0d frames instead of %0d", frames, N_FRAMES));
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// ==== upscale_trace.txt ====
# Frame record: back-pressure flag, valid-gap flag, then 12 input words (4 per input row)
# followed by 48 expected output words (8 per output row), all words in hex
0 0
ff102030 00405060 aa708090 01a0b0c0
00c0d0e0 12f00102 00030405 7f060708
00090a0b 550c0d0e 000f1011 80121314
00102030 00102030 00405060 00405060 00708090 00708090 00a0b0c0 00a0b0c0
00102030 00102030 00405060 00405060 00708090 00708090 00a0b0c0 00a0b0c0
00c0d0e0 00c0d0e0 00f00102 00f00102 00030405 00030405 00060708 00060708
00c0d0e0 00c0d0e0 00f00102 00f00102 00030405 00030405 00060708 00060708
00090a0b 00090a0b 000c0d0e 000c0d0e 000f1011 000f1011 00121314 00121314
00090a0b 00090a0b 000c0d0e 000c0d0e 000f1011 000f1011 00121314 00121314

1 0
11111111 22222222 33333333 44444444
55555555 66666666 77777777 88888888
99999999 aaaaaaaa bbbbbbbb cccccccc
00111111 00111111 00222222 00222222 00333333 00333333 00444444 00444444
00111111 00111111 00222222 00222222 00333333 00333333 00444444 00444444
00555555 00555555 00666666 00666666 00777777 00777777 00888888 00888888
00555555 00555555 00666666 00666666 00777777 00777777 00888888 00888888
00999999 00999999 00aaaaaa 00aaaaaa 00bbbbbb 00bbbbbb 00cccccc 00cccccc
00999999 00999999 00aaaaaa 00aaaaaa 00bbbbbb 00bbbbbb 00cccccc 00cccccc

1 1
de123456 00abcdef 00fedcba 34987654
00000000 00ffffff c3135724 00246813
00808080 007f7f7f 99010101 00020202
00123456 00123456 00abcdef 00abcdef 00fedcba 00fedcba 00987654 00987654
00123456 00123456 00abcdef 00abcdef 00fedcba 00fedcba 00987654 00987654
00000000 00000000 00ffffff 00ffffff 00135724 00135724 00246813 00246813
00000000 00000000 00ffffff 00ffffff 00135724 00135724 00246813 00246813
00808080 00808080 007f7f7f 007f7f7f 00010101 00010101 00020202 00020202
00808080 00808080 007f7f7f 007f7f7f 00010101 00010101 00020202 00020202

// ==== upscale.f ====
upscale_pkg.sv
stream_in.sv
upsp_ctrl.sv
upsp_counter.sv
upsp_line_buf.sv
upsp_out.sv
upscale_top.sv
tb_upscale.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the up-scaler testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --top-module tb_upscale -f upscale.f \
	&& ./obj_dir/Vtb_upscale > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "Verification passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
